/* source/l1_cache_pkg.sv */
/*
 * l1 data cache shared definitions
 * geometry, bus and frame structs, address decode union and controller states
 */
`default_nettype none

package l1_cache_pkg;

    localparam int WORD_W      = 32;
    localparam int CACHE_BYTES = 1024;
    localparam int BLOCK_WORDS = 2;
    localparam int N_SETS      = CACHE_BYTES / (BLOCK_WORDS * WORD_W / 8);
    localparam int SET_W       = $clog2(N_SETS);
    localparam int BLOCK_W     = $clog2(BLOCK_WORDS);
    localparam int TAG_W       = WORD_W - SET_W - BLOCK_W - 2;   // 2 byte offset bits

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [WORD_W/8-1:0] byte_en_t;

    // one request shape for both the core side and the memory side
    typedef struct packed {
        logic     ren;
        logic     wen;
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } bus_req_t;

    typedef struct packed {
        logic  busy;   // high until the access completes
        word_t rdata;
    } bus_resp_t;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag_bits;
    } cache_tag_t;

    typedef struct packed {
        cache_tag_t                  tag;
        word_t [BLOCK_WORDS-1:0]     data;
    } cache_frame_t;

    typedef struct packed {
        logic [TAG_W-1:0]   tag_bits;
        logic [SET_W-1:0]   set_bits;
        logic [BLOCK_W-1:0] block_bits;
        logic [1:0]         byte_bits;
    } cache_addr_fields_t;

    // same address seen as a flat word or split into cache fields
    typedef union packed {
        word_t              word;
        cache_addr_fields_t fields;
    } cache_addr_u;

    typedef enum logic [2:0] {
        INIT,
        HIT,
        FETCH,
        WB,
        FLUSH
    } cache_state_t;

endpackage

`default_nettype wire

/* source/cache_array.sv */
/*
 * cache frame storage
 * combinational read of one set, bit-masked synchronous write
 */
`timescale 1ns/1ps
`default_nettype none

module cache_array (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic [l1_cache_pkg::SET_W-1:0] set_sel,
    input  logic                           wen,
    input  l1_cache_pkg::cache_frame_t     wdata,
    input  l1_cache_pkg::cache_frame_t     wmask,   // 1 keeps the stored bit
    output l1_cache_pkg::cache_frame_t     rdata
);

    l1_cache_pkg::cache_frame_t frames [l1_cache_pkg::N_SETS];
    l1_cache_pkg::cache_frame_t merged;

    assign rdata = frames[set_sel];

    // old bits where the mask is set, new bits elsewhere
    assign merged = (rdata & wmask) | (wdata & ~wmask);

    // no writes land while reset is held
    always_ff @(posedge CLK) begin
        if (nRST && wen) begin
            frames[set_sel] <= merged;
        end
    end

endmodule

`default_nettype wire

/* source/block_walker.sv */
/*
 * word counter for refill and write-back
 * plus the set and word walker used by reset invalidation and flush
 */
`timescale 1ns/1ps
`default_nettype none

module block_walker (
    input  logic                             CLK,
    input  logic                             nRST,
    input  logic                             step_word,
    input  logic                             clear_word,
    input  logic                             step_flush,
    input  logic                             skip_block,
    input  logic                             clear_flush,
    output logic [l1_cache_pkg::BLOCK_W-1:0] word_num,
    output logic                             word_last,
    output logic [l1_cache_pkg::SET_W-1:0]   flush_set,
    output logic [l1_cache_pkg::BLOCK_W-1:0] flush_word,
    output logic                             flush_finish
);

    logic flush_word_last;
    logic set_last;
    logic next_set;

    // all ones marks the end since sizes are powers of two
    assign word_last       = &word_num;
    assign flush_word_last = &flush_word;
    assign set_last        = &flush_set;
    assign next_set        = skip_block || (step_flush && flush_word_last);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            word_num <= '0;
        end else if (clear_word) begin   // clear wins over step
            word_num <= '0;
        end else if (step_word) begin
            word_num <= word_num + l1_cache_pkg::BLOCK_W'(1);
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            flush_set    <= '0;
            flush_word   <= '0;
            flush_finish <= 1'b0;
        end else if (clear_flush) begin
            flush_set    <= '0;
            flush_word   <= '0;
            flush_finish <= 1'b0;
        end else if (next_set) begin
            flush_word <= '0;
            flush_set  <= flush_set + l1_cache_pkg::SET_W'(1);   // wraps to set 0
            if (set_last) begin
                flush_finish <= 1'b1;   // held until cleared
            end
        end else if (step_flush) begin
            flush_word <= flush_word + l1_cache_pkg::BLOCK_W'(1);
        end
    end

endmodule

`default_nettype wire

/* source/cache_ctrl.sv */
/*
 * cache controller FSM
 * hit detection, refill and write-back sequencing, pass-through and flush
 */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
    parameter l1_cache_pkg::word_t NONCACHE_START = 32'hF000_0000
) (
    input  logic                             CLK,
    input  logic                             nRST,
    input  l1_cache_pkg::bus_req_t           cpu_req,
    output l1_cache_pkg::bus_resp_t          cpu_resp,
    output l1_cache_pkg::bus_req_t           mem_req,
    input  l1_cache_pkg::bus_resp_t          mem_resp,
    input  logic                             flush,
    output logic                             flush_done,
    output logic [l1_cache_pkg::SET_W-1:0]   set_sel,
    output logic                             arr_wen,
    output l1_cache_pkg::cache_frame_t       arr_wdata,
    output l1_cache_pkg::cache_frame_t       arr_wmask,
    input  l1_cache_pkg::cache_frame_t       arr_rdata,
    output logic                             step_word,
    output logic                             clear_word,
    output logic                             step_flush,
    output logic                             skip_block,
    output logic                             clear_flush,
    input  logic [l1_cache_pkg::BLOCK_W-1:0] word_num,
    input  logic                             word_last,
    input  logic [l1_cache_pkg::SET_W-1:0]   flush_set,
    input  logic [l1_cache_pkg::BLOCK_W-1:0] flush_word,
    input  logic                             flush_finish
);

    l1_cache_pkg::cache_state_t state;
    l1_cache_pkg::cache_state_t next_state;
    l1_cache_pkg::cache_addr_u  req_addr;
    l1_cache_pkg::cache_addr_u  miss_addr;
    l1_cache_pkg::cache_addr_u  mem_addr;
    l1_cache_pkg::cache_tag_t   cur_tag;
    l1_cache_pkg::word_t        cpu_lanes;
    logic                       flush_req;
    logic                       flush_pend;
    logic                       cpu_active;
    logic                       pass_through;
    logic                       hit;
    logic                       victim_dirty;
    logic                       load_miss;

    // one byte enable bit per 8 data bits
    function automatic l1_cache_pkg::word_t lane_bits(input l1_cache_pkg::byte_en_t be);
        l1_cache_pkg::word_t bits;
        for (int i = 0; i < $bits(be); i++) begin
            bits[8*i +: 8] = {8{be[i]}};
        end
        return bits;
    endfunction

    assign req_addr.word = cpu_req.addr;
    assign cur_tag       = arr_rdata.tag;   // frame at set_sel
    assign cpu_lanes     = lane_bits(cpu_req.byte_en);
    assign cpu_active    = cpu_req.ren || cpu_req.wen;
    assign pass_through  = req_addr.word >= NONCACHE_START;
    assign hit           = !pass_through && cur_tag.valid &&
                           (cur_tag.tag_bits == req_addr.fields.tag_bits);
    assign victim_dirty  = cur_tag.valid && cur_tag.dirty;
    assign flush_pend    = flush || flush_req;

    // array index follows whoever owns the array this state
    always_comb begin
        case (state)
            l1_cache_pkg::INIT,
            l1_cache_pkg::FLUSH: set_sel = flush_set;
            l1_cache_pkg::FETCH,
            l1_cache_pkg::WB:    set_sel = miss_addr.fields.set_bits;
            default:             set_sel = req_addr.fields.set_bits;
        endcase
    end

    // block addresses toward memory
    always_comb begin
        mem_addr = '0;
        case (state)
            l1_cache_pkg::FLUSH: begin
                mem_addr.fields.tag_bits   = cur_tag.tag_bits;
                mem_addr.fields.set_bits   = flush_set;
                mem_addr.fields.block_bits = flush_word;
            end
            l1_cache_pkg::WB: begin   // victim lives at the miss set
                mem_addr.fields.tag_bits   = cur_tag.tag_bits;
                mem_addr.fields.set_bits   = miss_addr.fields.set_bits;
                mem_addr.fields.block_bits = word_num;
            end
            default: begin
                mem_addr.fields.tag_bits   = miss_addr.fields.tag_bits;
                mem_addr.fields.set_bits   = miss_addr.fields.set_bits;
                mem_addr.fields.block_bits = word_num;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= l1_cache_pkg::INIT;
            flush_req <= 1'b0;
        end else begin
            state     <= next_state;
            flush_req <= (state != l1_cache_pkg::FLUSH) && flush_pend;   // dropped once flushing
        end
    end

    // requested address of the current miss
    always_ff @(posedge CLK) begin
        if (load_miss) begin
            miss_addr <= req_addr;
        end
    end

    always_comb begin
        next_state     = state;
        cpu_resp.busy  = 1'b1;
        cpu_resp.rdata = '0;
        mem_req        = '0;
        arr_wen        = 1'b0;
        arr_wdata      = '0;
        arr_wmask      = '1;
        step_word      = 1'b0;
        clear_word     = 1'b0;
        step_flush     = 1'b0;
        skip_block     = 1'b0;
        clear_flush    = 1'b0;
        flush_done     = 1'b0;
        load_miss      = 1'b0;

        case (state)
            l1_cache_pkg::INIT: begin
                if (flush_finish) begin
                    clear_flush = 1'b1;
                    next_state  = l1_cache_pkg::HIT;
                end else begin
                    arr_wen    = 1'b1;   // zero one frame per cycle
                    arr_wmask  = '0;
                    skip_block = 1'b1;
                end
            end
            l1_cache_pkg::HIT: begin
                clear_word = 1'b1;
                if (flush_pend) begin
                    next_state = l1_cache_pkg::FLUSH;   // request waits behind the flush
                end else if (cpu_active && pass_through) begin
                    mem_req       = cpu_req;
                    mem_req.wdata = cpu_req.wdata & cpu_lanes;
                    cpu_resp      = mem_resp;
                end else if (cpu_active && hit) begin
                    cpu_resp.busy  = 1'b0;
                    cpu_resp.rdata = arr_rdata.data[req_addr.fields.block_bits];
                    if (cpu_req.wen) begin
                        arr_wen                                   = 1'b1;
                        arr_wdata.data[req_addr.fields.block_bits] = cpu_req.wdata;
                        arr_wmask.data[req_addr.fields.block_bits] = ~cpu_lanes;
                        arr_wdata.tag.dirty                        = 1'b1;
                        arr_wmask.tag.dirty                        = 1'b0;
                    end
                end else if (cpu_active) begin
                    load_miss  = 1'b1;
                    next_state = victim_dirty ? l1_cache_pkg::WB : l1_cache_pkg::FETCH;
                end
            end
            l1_cache_pkg::FETCH: begin
                mem_req.ren     = 1'b1;
                mem_req.addr    = mem_addr.word;
                mem_req.byte_en = '1;
                if (!mem_resp.busy) begin
                    arr_wen                  = 1'b1;
                    arr_wdata.data[word_num] = mem_resp.rdata;
                    arr_wmask.data[word_num] = '0;
                    arr_wdata.tag.valid      = word_last;   // valid only with the last word
                    arr_wdata.tag.tag_bits   = miss_addr.fields.tag_bits;
                    arr_wmask.tag            = '0;
                    step_word                = 1'b1;
                    if (word_last) begin
                        clear_word = 1'b1;
                        next_state = l1_cache_pkg::HIT;
                    end
                end
            end
            l1_cache_pkg::WB: begin
                mem_req.wen     = 1'b1;
                mem_req.addr    = mem_addr.word;
                mem_req.wdata   = arr_rdata.data[word_num];
                mem_req.byte_en = '1;
                if (!mem_resp.busy) begin
                    step_word = 1'b1;
                    if (word_last) begin
                        arr_wen             = 1'b1;   // victim now clean and invalid
                        arr_wmask.tag.valid = 1'b0;
                        arr_wmask.tag.dirty = 1'b0;
                        clear_word          = 1'b1;
                        next_state          = l1_cache_pkg::FETCH;
                    end
                end
            end
            l1_cache_pkg::FLUSH: begin
                if (flush_finish) begin
                    flush_done  = 1'b1;
                    clear_flush = 1'b1;
                    next_state  = l1_cache_pkg::HIT;
                end else if (victim_dirty) begin
                    mem_req.wen     = 1'b1;
                    mem_req.addr    = mem_addr.word;
                    mem_req.wdata   = arr_rdata.data[flush_word];
                    mem_req.byte_en = '1;
                    if (!mem_resp.busy) begin
                        step_flush = 1'b1;
                        if (&flush_word) begin   // frame dropped after its last word
                            arr_wen   = 1'b1;
                            arr_wmask = '0;
                        end
                    end
                end else begin
                    arr_wen    = 1'b1;
                    arr_wmask  = '0;
                    skip_block = 1'b1;
                end
            end
            default: next_state = l1_cache_pkg::INIT;
        endcase
    end

endmodule

`default_nettype wire

/* source/l1_cache.sv */
/*
 * direct-mapped write-back l1 data cache
 * controller, frame storage and block walker
 */
`timescale 1ns/1ps
`default_nettype none

module l1_cache #(
    parameter l1_cache_pkg::word_t NONCACHE_START = 32'hF000_0000
) (
    input  logic                    CLK,
    input  logic                    nRST,
    input  l1_cache_pkg::bus_req_t  cpu_req,
    output l1_cache_pkg::bus_resp_t cpu_resp,
    output l1_cache_pkg::bus_req_t  mem_req,
    input  l1_cache_pkg::bus_resp_t mem_resp,
    input  logic                    flush,
    output logic                    flush_done
);

    // array port
    logic [l1_cache_pkg::SET_W-1:0]   set_sel;
    logic                             arr_wen;
    l1_cache_pkg::cache_frame_t       arr_wdata;
    l1_cache_pkg::cache_frame_t       arr_wmask;
    l1_cache_pkg::cache_frame_t       arr_rdata;

    // walker strobes and counts
    logic                             step_word;
    logic                             clear_word;
    logic                             step_flush;
    logic                             skip_block;
    logic                             clear_flush;
    logic [l1_cache_pkg::BLOCK_W-1:0] word_num;
    logic                             word_last;
    logic [l1_cache_pkg::SET_W-1:0]   flush_set;
    logic [l1_cache_pkg::BLOCK_W-1:0] flush_word;
    logic                             flush_finish;

    cache_ctrl #(
        .NONCACHE_START(NONCACHE_START)
    ) i_cache_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .cpu_req      (cpu_req),
        .cpu_resp     (cpu_resp),
        .mem_req      (mem_req),
        .mem_resp     (mem_resp),
        .flush        (flush),
        .flush_done   (flush_done),
        .set_sel      (set_sel),
        .arr_wen      (arr_wen),
        .arr_wdata    (arr_wdata),
        .arr_wmask    (arr_wmask),
        .arr_rdata    (arr_rdata),
        .step_word    (step_word),
        .clear_word   (clear_word),
        .step_flush   (step_flush),
        .skip_block   (skip_block),
        .clear_flush  (clear_flush),
        .word_num     (word_num),
        .word_last    (word_last),
        .flush_set    (flush_set),
        .flush_word   (flush_word),
        .flush_finish (flush_finish)
    );

    cache_array i_cache_array (
        .CLK     (CLK),
        .nRST    (nRST),
        .set_sel (set_sel),
        .wen     (arr_wen),
        .wdata   (arr_wdata),
        .wmask   (arr_wmask),
        .rdata   (arr_rdata)
    );

    block_walker i_block_walker (
        .CLK          (CLK),
        .nRST         (nRST),
        .step_word    (step_word),
        .clear_word   (clear_word),
        .step_flush   (step_flush),
        .skip_block   (skip_block),
        .clear_flush  (clear_flush),
        .word_num     (word_num),
        .word_last    (word_last),
        .flush_set    (flush_set),
        .flush_word   (flush_word),
        .flush_finish (flush_finish)
    );

endmodule

`default_nettype wire

/* sim/l1_cache_sva.sv */
/*
 * memory bus protocol assertions for the cache controller
 */
`timescale 1ns/1ps
`default_nettype none

module l1_cache_sva (
    input logic                    CLK,
    input logic                    nRST,
    input l1_cache_pkg::bus_req_t  mem_req,
    input l1_cache_pkg::bus_resp_t mem_resp,
    input logic                    flush_done
);

    a_no_read_and_write: assert property (
        @(posedge CLK) disable iff (!nRST) !(mem_req.ren && mem_req.wen)
    ) else $error("memory read and write requested together");

    a_flush_done_pulse: assert property (
        @(posedge CLK) disable iff (!nRST) flush_done |=> !flush_done
    ) else $error("flush_done held longer than one cycle");

    // request frozen until memory drops busy
    a_hold_while_busy: assert property (
        @(posedge CLK) disable iff (!nRST)
        (mem_resp.busy && (mem_req.ren || mem_req.wen)) |=> $stable(mem_req)
    ) else $error("memory request changed while busy");

endmodule

bind cache_ctrl l1_cache_sva i_l1_cache_sva (
    .CLK        (CLK),
    .nRST       (nRST),
    .mem_req    (mem_req),
    .mem_resp   (mem_resp),
    .flush_done (flush_done)
);

`default_nettype wire

/* sim/tb_l1_cache.sv */
/*
 * l1 cache testbench
 * random cached, non-cacheable and flush traffic checked against a byte reference model
 */
`timescale 1ns/1ps
`default_nettype none

module tb_l1_cache;

    localparam int N_OPS       = 600;
    localparam int CYCLE_LIMIT = N_OPS * 40;
    localparam l1_cache_pkg::word_t NC_BASE = 32'hF000_0000;

    logic                    CLK;
    logic                    nRST;
    l1_cache_pkg::bus_req_t  cpu_req;
    l1_cache_pkg::bus_resp_t cpu_resp;
    l1_cache_pkg::bus_req_t  mem_req;
    l1_cache_pkg::bus_resp_t mem_resp;
    logic                    flush;
    logic                    flush_done;

    logic [31:0]         rng;
    l1_cache_pkg::word_t mem [l1_cache_pkg::word_t];   // sparse, keyed by word address
    logic [7:0]          ref_bytes [4096];             // cacheable window as the core sees it
    l1_cache_pkg::word_t read_log [$];
    int                  wait_left;
    int                  cycle_count;

    l1_cache #(
        .NONCACHE_START(NC_BASE)
    ) i_l1_cache (
        .CLK        (CLK),
        .nRST       (nRST),
        .cpu_req    (cpu_req),
        .cpu_resp   (cpu_resp),
        .mem_req    (mem_req),
        .mem_resp   (mem_resp),
        .flush      (flush),
        .flush_done (flush_done)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // preset content depends on every address bit
    function automatic l1_cache_pkg::word_t fill_word(input l1_cache_pkg::word_t a);
        return (a * 32'h9E37_79B1) ^ 32'h3C5A_96E1;
    endfunction

    function automatic l1_cache_pkg::word_t mem_peek(input l1_cache_pkg::word_t a);
        l1_cache_pkg::word_t key;
        key = {a[31:2], 2'b00};
        if (mem.exists(key)) begin
            return mem[key];
        end
        return fill_word(key);
    endfunction

    function automatic l1_cache_pkg::word_t ref_word(input l1_cache_pkg::word_t a);
        int base;
        base = int'({a[11:2], 2'b00});
        return {ref_bytes[base+3], ref_bytes[base+2], ref_bytes[base+1], ref_bytes[base]};
    endfunction

    function automatic l1_cache_pkg::byte_en_t pick_byte_en(input logic [2:0] sel);
        case (sel)
            3'd2:    return 4'b0011;   // half words
            3'd3:    return 4'b1100;
            3'd4:    return 4'b0001;   // single bytes
            3'd5:    return 4'b0010;
            3'd6:    return 4'b0100;
            3'd7:    return 4'b1000;
            default: return 4'b1111;
        endcase
    endfunction

    task automatic mem_write(input l1_cache_pkg::word_t a, input l1_cache_pkg::word_t data,
                             input l1_cache_pkg::byte_en_t be);
        l1_cache_pkg::word_t w;
        w = mem_peek(a);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                w[8*b +: 8] = data[8*b +: 8];
            end
        end
        mem[{a[31:2], 2'b00}] = w;
    endtask

    task automatic ref_write(input l1_cache_pkg::word_t a, input l1_cache_pkg::word_t data,
                             input l1_cache_pkg::byte_en_t be);
        int base;
        base = int'({a[11:2], 2'b00});
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                ref_bytes[base+b] = data[8*b +: 8];
            end
        end
    endtask

    task automatic stop_run();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input l1_cache_pkg::word_t expected,
                               input l1_cache_pkg::word_t actual);
        assert (actual === expected) else begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            stop_run();
        end
    endtask

    // non-cacheable write seen on the memory side with only its lanes kept
    task automatic check_pass_write(input l1_cache_pkg::word_t a,
                                    input l1_cache_pkg::word_t data,
                                    input l1_cache_pkg::byte_en_t be);
        l1_cache_pkg::word_t masked;
        masked = '0;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                masked[8*b +: 8] = data[8*b +: 8];
            end
        end
        check_value("pass_write_wen", 32'd1, 32'(mem_req.wen));
        check_value("pass_write_addr", a, mem_req.addr);
        check_value("pass_write_byte_en", 32'(be), 32'(mem_req.byte_en));
        check_value("pass_write_data", masked, mem_req.wdata);
    endtask

    // runs from 1 ns after an edge to 1 ns after the completing edge
    task automatic cpu_access(input logic write, input l1_cache_pkg::word_t a,
                              input l1_cache_pkg::word_t data,
                              input l1_cache_pkg::byte_en_t be,
                              output l1_cache_pkg::word_t rdata);
        logic done;
        logic first;
        cpu_req.ren     = !write;
        cpu_req.wen     = write;
        cpu_req.addr    = a;
        cpu_req.wdata   = data;
        cpu_req.byte_en = be;
        done  = 1'b0;
        first = 1'b1;
        while (!done) begin
            #2;   // after the memory model has answered
            if (first && write && a >= NC_BASE) begin
                check_pass_write(a, data, be);
            end
            first = 1'b0;
            if (!cpu_resp.busy) begin
                done = 1'b1;
            end else begin
                @(posedge CLK);
                #1;
            end
        end
        rdata = cpu_resp.rdata;
        @(posedge CLK);
        #1;
        cpu_req = '0;
    endtask

    task automatic check_memory(input string name);
        for (int a = 0; a < 4096; a += 4) begin
            check_value(name, ref_word(32'(a)), mem_peek(32'(a)));
        end
    endtask

    task automatic run_flush();
        int pulses;
        pulses = 0;
        flush  = 1'b1;
        while (pulses == 0) begin
            #2;
            if (flush_done) begin
                pulses++;
            end
            @(posedge CLK);
            #1;
            flush = 1'b0;   // single cycle request is latched
        end
        repeat (4) begin
            #2;
            if (flush_done) begin
                pulses++;
            end
            @(posedge CLK);
            #1;
        end
        check_value("flush_done_pulses", 32'd1, 32'(pulses));
        check_memory("flush_memory");
    endtask

    initial begin
        CLK = 1'b0;
        forever begin
            #4 CLK = ~CLK;
        end
    end

    // memory model with random busy of 0 to 3 cycles per access
    initial begin
        mem_resp  = '0;
        wait_left = 0;
        forever begin
            @(posedge CLK);
            #2;
            if (mem_req.ren || mem_req.wen) begin
                if (mem_resp.busy) begin
                    wait_left = wait_left - 1;   // same access still pending
                end else begin
                    rng       = xorshift(rng);
                    wait_left = int'(rng % 32'd4);
                end
            end else begin
                wait_left = 0;
            end
            mem_resp.busy  = (wait_left != 0);
            mem_resp.rdata = mem_peek(mem_req.addr);
            if ((mem_req.ren || mem_req.wen) && !mem_resp.busy) begin
                if (mem_req.wen) begin
                    mem_write(mem_req.addr, mem_req.wdata, mem_req.byte_en);
                end else begin
                    read_log.push_back(mem_req.addr);
                end
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("ERROR timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
        stop_run();
    end

    initial begin
        l1_cache_pkg::word_t      addr;
        l1_cache_pkg::word_t      wdata;
        l1_cache_pkg::word_t      rdata;
        l1_cache_pkg::word_t      sel;
        l1_cache_pkg::byte_en_t   be;
        rng     = 32'd95394;
        nRST    = 1'b0;
        flush   = 1'b0;
        cpu_req = '0;
        for (int a = 0; a < 4096; a += 4) begin
            ref_write(32'(a), fill_word(32'(a)), 4'hF);
        end
        repeat (4) @(posedge CLK);
        #1;
        nRST = 1'b1;

        // memory bus and flush_done stay quiet through invalidation
        repeat (140) begin
            #2;
            assert (!(mem_req.ren || mem_req.wen)) else begin
                $display("ERROR memory request issued before any processor request");
                stop_run();
            end
            assert (!flush_done) else begin
                $display("ERROR flush_done raised without a flush request");
                stop_run();
            end
            @(posedge CLK);
            #1;
        end

        addr = 32'h0000_0A4C;
        read_log.delete();
        cpu_access(1'b0, addr, '0, 4'hF, rdata);
        check_value("reset_read", ref_word(addr), rdata);
        check_value("reset_miss_reads", 32'd2, 32'(read_log.size()));
        check_value("reset_miss_word0", {addr[31:3], 3'b000}, read_log[0]);
        check_value("reset_miss_word1", {addr[31:3], 3'b100}, read_log[1]);

        for (int op = 0; op < N_OPS; op++) begin
            rng   = xorshift(rng);
            sel   = rng;
            rng   = xorshift(rng);
            wdata = rng;
            be    = pick_byte_en(sel[24:22]);
            if (sel[4:0] == 5'd0) begin
                run_flush();
            end else if (sel[4:0] < 5'd4) begin
                addr = {26'h3C0_0000, sel[13:10], 2'b00};   // small window at NC_BASE
                cpu_access(sel[25], addr, wdata, be, rdata);
                if (!sel[25]) begin
                    check_value("pass_read", mem_peek(addr), rdata);
                end
            end else begin
                // 4 tags over 8 sets for frequent conflicts
                addr = {20'h0, sel[21:20], 4'h0, sel[15:13], sel[9], 2'b00};
                cpu_access(sel[25], addr, wdata, be, rdata);
                if (sel[25]) begin
                    ref_write(addr, wdata, be);
                end else begin
                    check_value("cached_read", ref_word(addr), rdata);
                end
            end
        end

        run_flush();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* l1_cache.f */
source/l1_cache_pkg.sv
source/cache_array.sv
source/block_walker.sv
source/cache_ctrl.sv
source/l1_cache.sv
sim/l1_cache_sva.sv
sim/tb_l1_cache.sv

/* Makefile */
TB = tb_l1_cache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f l1_cache.f --top-module l1_cache

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f l1_cache.f \
		--top-module $(TB) -o $(TB)
	./obj_dir/$(TB) | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" sim.log || (echo "simulation ended without passing"; exit 1)

clean:
	rm -rf obj_dir sim.log
